// File: common/dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// byte offsets in the register window
`define DMA_CONTROL_ADDR 15'h0000
`define DMA_LOCAL_ADDR   15'h0002
`define DMA_PERIPH_ADDR  15'h0004
`define DMA_COUNT_ADDR   15'h0006

// cpu addr bit that selects the local ram window
`define DMA_RAM_WINDOW_BIT 15

// local ram holds 2**N 16-bit words
`define DMA_RAM_DEPTH_LOG2 8

`define DMA_DRAM_ADDR_W 24

`endif

// File: common/dma_pkg.sv
package dma_pkg;

  // control register opcode field
  typedef enum logic [2:0] {
    OP_TO_DRAM   = 3'd0,  // local pairs -> dram words
    OP_FROM_DRAM = 3'd1,  // dram words -> local pairs
    OP_RESERVED  = 3'd7   // any code from 2 up
  } dma_op_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    // local ram -> dram
    ST_DW_ADDR,
    ST_DW_LOW,
    ST_DW_HIGH,
    ST_DW_WAIT,
    // dram -> local ram
    ST_DR_REQ,
    ST_DR_WAIT,
    ST_DR_LOW,
    ST_DR_HIGH
  } dma_state_e;

endpackage

// File: dma/dma_regs.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dma_regs
  import dma_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           en,
  input  logic                           write_enable,
  input  logic [15:0]                    addr,
  input  logic [15:0]                    data_in,
  input  logic                           busy,
  output logic                           start,
  output dma_op_e                        op,
  output logic [`DMA_RAM_DEPTH_LOG2-1:0] local_addr_init,
  output logic [`DMA_DRAM_ADDR_W-1:0]    dram_addr_init,
  output logic [15:0]                    count_init,
  output logic [15:0]                    status_rdata
);

  logic [14:0] reg_off;
  logic        reg_wr;
  logic        reg_rd;
  logic        ctrl_wr;

  assign reg_off = {addr[14:1], 1'b0};  // bit 0 ignored
  assign reg_wr  = en & write_enable & ~addr[`DMA_RAM_WINDOW_BIT];
  assign reg_rd  = en & ~write_enable & ~addr[`DMA_RAM_WINDOW_BIT];
  assign ctrl_wr = reg_wr & (reg_off == `DMA_CONTROL_ADDR);

  // start goes out in the write cycle so busy rises on the next one
  assign start = ctrl_wr & ~busy;

  // opcode travels with start
  always_comb begin
    case (data_in[2:0])
      3'd0:    op = OP_TO_DRAM;
      3'd1:    op = OP_FROM_DRAM;
      default: op = OP_RESERVED;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      local_addr_init <= '0;
      dram_addr_init  <= '0;
      count_init      <= '0;
    end else if (reg_wr) begin
      case (reg_off)
        `DMA_LOCAL_ADDR:  local_addr_init <= data_in[`DMA_RAM_DEPTH_LOG2:1]; // bytes -> words
        `DMA_PERIPH_ADDR: dram_addr_init  <= {data_in, 8'h00};
        `DMA_COUNT_ADDR:  count_init      <= {2'b00, data_in[15:2]}; // bytes -> 32-bit words
        default: ;
      endcase
    end
  end

  // only control reads back anything
  always_ff @(posedge clk) begin
    if (rst) begin
      status_rdata <= '0;
    end else if (reg_rd) begin
      status_rdata <= (reg_off == `DMA_CONTROL_ADDR) ? {15'd0, busy} : 16'd0;
    end
  end

endmodule

// File: dma/dma_engine.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dma_engine
  import dma_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  dma_op_e                        op,
  input  logic [`DMA_RAM_DEPTH_LOG2-1:0] local_addr_init,
  input  logic [`DMA_DRAM_ADDR_W-1:0]    dram_addr_init,
  input  logic [15:0]                    count_init,
  input  logic [15:0]                    ram_rdata,
  input  logic [31:0]                    dram_data_in,
  input  logic                           dram_data_valid,
  input  logic                           dram_write_complete,
  output logic                           busy,
  output logic [`DMA_RAM_DEPTH_LOG2-1:0] ram_addr,
  output logic [15:0]                    ram_wdata,
  output logic                           ram_we,
  output logic [`DMA_DRAM_ADDR_W-1:0]    dram_addr,
  output logic [31:0]                    dram_data_out,
  output logic                           dram_req_read,
  output logic                           dram_req_write
);

  localparam int AW = `DMA_RAM_DEPTH_LOG2;
  localparam int DW = `DMA_DRAM_ADDR_W;

  dma_state_e    state;
  logic [AW-1:0] local_addr;   // working copies
  logic [DW-1:0] remote_addr;
  logic [15:0]   count;
  logic [31:0]   read_word;    // dram word being split into ram
  logic          last_word;

  assign last_word = (count == 16'd0);

  // the ram port follows the working local address directly
  assign ram_addr  = local_addr;
  assign ram_we    = (state == ST_DR_LOW) | (state == ST_DR_HIGH);
  assign ram_wdata = (state == ST_DR_LOW) ? read_word[15:0] : read_word[31:16];

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= ST_IDLE;
      busy           <= 1'b0;
      dram_req_read  <= 1'b0;
      dram_req_write <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          busy <= start;  // reserved op shows one busy cycle
          if (start) begin
            case (op)
              OP_TO_DRAM:   state <= ST_DW_ADDR;
              OP_FROM_DRAM: state <= ST_DR_REQ;
              default:      state <= ST_IDLE;
            endcase
          end
        end
        ST_DW_ADDR: state <= ST_DW_LOW;
        ST_DW_LOW:  state <= ST_DW_HIGH;
        ST_DW_HIGH: begin
          dram_req_write <= 1'b1;
          state          <= ST_DW_WAIT;
        end
        ST_DW_WAIT: begin
          // hold request, addr and data until complete
          if (dram_write_complete) begin
            dram_req_write <= 1'b0;
            if (last_word) begin
              busy  <= 1'b0;
              state <= ST_IDLE;
            end else begin
              state <= ST_DW_ADDR;
            end
          end
        end
        ST_DR_REQ: begin
          dram_req_read <= 1'b1;
          state         <= ST_DR_WAIT;
        end
        ST_DR_WAIT: begin
          dram_req_read <= 1'b0;  // single cycle pulse
          if (dram_data_valid) begin
            state <= ST_DR_LOW;
          end
        end
        ST_DR_LOW:  state <= ST_DR_HIGH;
        ST_DR_HIGH: begin
          if (last_word) begin
            busy  <= 1'b0;
            state <= ST_IDLE;
          end else begin
            state <= ST_DR_REQ;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // addresses, count and data words
  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: begin
        if (start) begin
          local_addr  <= local_addr_init;
          remote_addr <= dram_addr_init;
          count       <= count_init;
        end
      end
      ST_DW_ADDR: local_addr <= local_addr + AW'(1);
      ST_DW_LOW: begin
        dram_data_out[15:0] <= ram_rdata;  // low word first
        local_addr          <= local_addr + AW'(1);
      end
      ST_DW_HIGH: begin
        dram_data_out[31:16] <= ram_rdata;
        dram_addr            <= remote_addr;
        remote_addr          <= remote_addr + DW'(2);
        count                <= count - 16'd1;
      end
      ST_DR_REQ: begin
        dram_addr   <= remote_addr;
        remote_addr <= remote_addr + DW'(2);
        count       <= count - 16'd1;
      end
      ST_DR_WAIT: begin
        if (dram_data_valid) begin
          read_word <= dram_data_in;
        end
      end
      ST_DR_LOW, ST_DR_HIGH: local_addr <= local_addr + AW'(1);
      default: ;
    endcase
  end

endmodule

// File: rtl/local_ram.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module local_ram (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           busy,
  input  logic                           cpu_sel,
  input  logic                           cpu_we,
  input  logic [`DMA_RAM_DEPTH_LOG2-1:0] cpu_addr,
  input  logic [15:0]                    cpu_wdata,
  input  logic [`DMA_RAM_DEPTH_LOG2-1:0] dma_addr,
  input  logic [15:0]                    dma_wdata,
  input  logic                           dma_we,
  output logic [15:0]                    rdata,
  output logic [15:0]                    cpu_rdata
);

  localparam int DEPTH = 1 << `DMA_RAM_DEPTH_LOG2;

  logic [15:0]                    mem [DEPTH];
  logic [`DMA_RAM_DEPTH_LOG2-1:0] addr;
  logic [15:0]                    wdata;
  logic                           we;
  logic [15:0]                    rd_q;
  logic                           cpu_rd_q;

  // engine owns the port while busy
  assign addr  = busy ? dma_addr : cpu_addr;
  assign wdata = busy ? dma_wdata : cpu_wdata;
  assign we    = busy ? dma_we : (cpu_sel & cpu_we);

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rd_q <= mem[addr];
  end

  always_ff @(posedge clk) begin
    if (rst) cpu_rd_q <= 1'b0;
    else     cpu_rd_q <= cpu_sel & ~cpu_we & ~busy;
  end

  assign rdata     = rd_q;
  assign cpu_rdata = cpu_rd_q ? rd_q : 16'd0;  // zero when the cpu was locked out

endmodule

// File: rtl/dma_subsystem.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dma_subsystem
  import dma_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  logic                        write_enable,
  input  logic [15:0]                 addr,
  input  logic [15:0]                 data_in,
  output logic [15:0]                 data_out,
  output logic                        dma_status,
  output logic [`DMA_DRAM_ADDR_W-1:0] dram_addr,
  output logic [31:0]                 dram_data_out,
  output logic                        dram_req_read,
  output logic                        dram_req_write,
  input  logic [31:0]                 dram_data_in,
  input  logic                        dram_data_valid,
  input  logic                        dram_write_complete
);

  logic                           start;
  dma_op_e                        op;
  logic [`DMA_RAM_DEPTH_LOG2-1:0] local_addr_init;
  logic [`DMA_DRAM_ADDR_W-1:0]    dram_addr_init;
  logic [15:0]                    count_init;
  logic [15:0]                    status_rdata;
  logic                           busy;
  logic [`DMA_RAM_DEPTH_LOG2-1:0] ram_addr;
  logic [15:0]                    ram_wdata;
  logic                           ram_we;
  logic [15:0]                    ram_rdata;
  logic [15:0]                    cpu_rdata;
  logic                           rd_ram_q;  // last read hit the ram window

  assign dma_status = busy;

  dma_regs u_regs (
    .clk             (clk),
    .rst             (rst),
    .en              (en),
    .write_enable    (write_enable),
    .addr            (addr),
    .data_in         (data_in),
    .busy            (busy),
    .start           (start),
    .op              (op),
    .local_addr_init (local_addr_init),
    .dram_addr_init  (dram_addr_init),
    .count_init      (count_init),
    .status_rdata    (status_rdata)
  );

  dma_engine u_engine (
    .clk                 (clk),
    .rst                 (rst),
    .start               (start),
    .op                  (op),
    .local_addr_init     (local_addr_init),
    .dram_addr_init      (dram_addr_init),
    .count_init          (count_init),
    .ram_rdata           (ram_rdata),
    .dram_data_in        (dram_data_in),
    .dram_data_valid     (dram_data_valid),
    .dram_write_complete (dram_write_complete),
    .busy                (busy),
    .ram_addr            (ram_addr),
    .ram_wdata           (ram_wdata),
    .ram_we              (ram_we),
    .dram_addr           (dram_addr),
    .dram_data_out       (dram_data_out),
    .dram_req_read       (dram_req_read),
    .dram_req_write      (dram_req_write)
  );

  local_ram u_ram (
    .clk       (clk),
    .rst       (rst),
    .busy      (busy),
    .cpu_sel   (en & addr[`DMA_RAM_WINDOW_BIT]),
    .cpu_we    (write_enable),
    .cpu_addr  (addr[`DMA_RAM_DEPTH_LOG2:1]),
    .cpu_wdata (data_in),
    .dma_addr  (ram_addr),
    .dma_wdata (ram_wdata),
    .dma_we    (ram_we),
    .rdata     (ram_rdata),
    .cpu_rdata (cpu_rdata)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ram_q <= 1'b0;
    end else if (en & ~write_enable) begin
      rd_ram_q <= addr[`DMA_RAM_WINDOW_BIT];
    end
  end

  assign data_out = rd_ram_q ? cpu_rdata : status_rdata;

endmodule

// File: test/dram_model.sv
`timescale 1ns/100ps

module dram_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [23:0] dram_addr,
  input  logic [31:0] dram_data_out,
  input  logic        dram_req_read,
  input  logic        dram_req_write,
  output logic [31:0] dram_data_in,
  output logic        dram_data_valid,
  output logic        dram_write_complete
);

  logic [31:0] mem [4096];
  logic [2:0]  wait_cnt = 3'd0;   // cycles left on the open request
  logic        is_write = 1'b0;
  logic [11:0] req_idx = 12'd0;
  logic [31:0] req_wdata = 32'd0;
  logic [31:0] rdata_q = 32'd0;
  logic        valid_q = 1'b0;
  logic        done_q = 1'b0;
  logic        load_go = 1'b0;    // preload slot from the testbench
  logic [11:0] load_idx = 12'd0;
  logic [31:0] load_data = 32'd0;

  assign dram_data_in        = rdata_q;
  assign dram_data_valid     = valid_q;
  assign dram_write_complete = done_q;

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4096; i++) begin
        mem[i] = {20'h5a5a5, i[11:0]};
      end
      wait_cnt <= 3'd0;
      valid_q  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
      if (load_go) begin
        mem[load_idx] = load_data;
      end
      if (wait_cnt != 3'd0) begin
        wait_cnt <= wait_cnt - 3'd1;
        if (wait_cnt == 3'd1) begin
          if (is_write) begin
            mem[req_idx] = req_wdata;
            done_q <= 1'b1;
          end else begin
            rdata_q <= mem[req_idx];
            valid_q <= 1'b1;
          end
        end
      end else if (!done_q && (dram_req_read || dram_req_write)) begin
        // write request is still high on its complete cycle
        req_idx   <= dram_addr[12:1];
        req_wdata <= dram_data_out;
        is_write  <= dram_req_write;
        wait_cnt  <= 3'(32'd1 + ($urandom % 32'd6));  // 1 to 6 cycles
      end
    end
  end

  // call on a falling edge, returns on the next one
  task automatic preload_word(input logic [23:0] byte_addr, input logic [31:0] data);
    load_idx  = byte_addr[12:1];
    load_data = data;
    load_go   = 1'b1;
    @(negedge clk);
    load_go   = 1'b0;
  endtask

  function automatic logic [31:0] peek_word(input logic [23:0] byte_addr);
    return mem[byte_addr[12:1]];
  endfunction

endmodule

// File: test/tb_dma.sv
`timescale 1ns/100ps
`include "dma_cfg.svh"

module tb_dma
  import dma_pkg::*;
();

  localparam string CASE_FILE    = "test/dma_cases.txt";
  localparam int    IDLE_TIMEOUT = 2000;  // cycles

  logic                        clk;
  logic                        rst;
  logic                        en;
  logic                        write_enable;
  logic [15:0]                 addr;
  logic [15:0]                 data_in;
  logic [15:0]                 data_out;
  logic                        dma_status;
  logic [`DMA_DRAM_ADDR_W-1:0] dram_addr;
  logic [31:0]                 dram_data_out;
  logic                        dram_req_read;
  logic                        dram_req_write;
  logic [31:0]                 dram_data_in;
  logic                        dram_data_valid;
  logic                        dram_write_complete;
  int                          checks_done = 0;

  dma_subsystem UUT (
    .clk                 (clk),
    .rst                 (rst),
    .en                  (en),
    .write_enable        (write_enable),
    .addr                (addr),
    .data_in             (data_in),
    .data_out            (data_out),
    .dma_status          (dma_status),
    .dram_addr           (dram_addr),
    .dram_data_out       (dram_data_out),
    .dram_req_read       (dram_req_read),
    .dram_req_write      (dram_req_write),
    .dram_data_in        (dram_data_in),
    .dram_data_valid     (dram_data_valid),
    .dram_write_complete (dram_write_complete)
  );

  dram_model u_dram (
    .clk                 (clk),
    .rst                 (rst),
    .dram_addr           (dram_addr),
    .dram_data_out       (dram_data_out),
    .dram_req_read       (dram_req_read),
    .dram_req_write      (dram_req_write),
    .dram_data_in        (dram_data_in),
    .dram_data_valid     (dram_data_valid),
    .dram_write_complete (dram_write_complete)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word16(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks_done++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_word32(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks_done++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_status(input logic got, input logic exp, input string what);
    checks_done++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_op(input dma_op_e got, input dma_op_e exp, input string what);
    checks_done++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %s, expected %s", $time, what, got.name(),
               exp.name());
      stop_with_failure();
    end
  endtask

  // opcode field 0 and 1 are transfers, the rest reserved
  function automatic dma_op_e expected_op(input logic [2:0] code);
    if (code > 3'd1) begin
      return OP_RESERVED;
    end else begin
      return dma_op_e'(code);  // transfer codes equal their enum values
    end
  endfunction

  task automatic bus_write(input logic [15:0] a, input logic [15:0] d);
    logic is_ctrl;
    is_ctrl      = (a[`DMA_RAM_WINDOW_BIT] == 1'b0) && (a[14:1] == 14'd0);
    en           = 1'b1;
    write_enable = 1'b1;
    addr         = a;
    data_in      = d;
    @(negedge clk);
    if (is_ctrl) begin
      check_op(UUT.op, expected_op(d[2:0]), "opcode decode");
    end
    en           = 1'b0;
    write_enable = 1'b0;
    if (is_ctrl) begin
      check_status(dma_status, 1'b1, "busy after control write");  // accepted or ignored
    end
  endtask

  task automatic bus_read(input logic [15:0] a, input logic [15:0] exp);
    en           = 1'b1;
    write_enable = 1'b0;
    addr         = a;
    @(negedge clk);
    en = 1'b0;
    check_word16(data_out, exp, $sformatf("bus read at %h", a));
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (dma_status !== 1'b0 && cycles < IDLE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (dma_status !== 1'b0) begin
      $display("timeout: DMA still busy after %0d cycles", cycles);
      stop_with_failure();
    end
  endtask

  task automatic read_fields(input int fd, input logic [7:0] kind,
                             output logic [31:0] a, output logic [31:0] d);
    int code;
    code = $fscanf(fd, "%h %h", a, d);
    if (code != 2) begin
      $display("malformed %c line in the case file", kind);
      stop_with_failure();
    end
  endtask

  task automatic skip_rest_of_line(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  initial begin
    int          fd;
    int          code;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] d;

    void'($urandom(32'hb120d447));
    rst          = 1'b1;
    en           = 1'b0;
    write_enable = 1'b0;
    addr         = 16'd0;
    data_in      = 16'd0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_status(dma_status, 1'b0, "busy after reset");

    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the case file %s", CASE_FILE);
      stop_with_failure();
    end
    code = $fscanf(fd, " %c", kind);
    while (code == 1) begin
      case (kind)
        "#": skip_rest_of_line(fd);
        "W": begin
          read_fields(fd, kind, a, d);
          bus_write(a[15:0], d[15:0]);
        end
        "R": begin
          read_fields(fd, kind, a, d);
          bus_read(a[15:0], d[15:0]);
        end
        "P": begin
          read_fields(fd, kind, a, d);
          u_dram.preload_word(a[23:0], d);
        end
        "E": begin
          read_fields(fd, kind, a, d);
          check_word32(u_dram.peek_word(a[23:0]), d, $sformatf("dram word at %h", a[23:0]));
        end
        "G": wait_idle();
        default: begin
          $display("unknown line kind %c in the case file", kind);
          stop_with_failure();
        end
      endcase
      code = $fscanf(fd, " %c", kind);
    end
    $fclose(fd);

    if (checks_done < 2) begin
      $display("the case file held no checks");
      stop_with_failure();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// File: test/dma_cases.txt
# kind addr data: W bus write, R bus read and expected data, G wait for idle
# P dram preload, E dram expected word; P and E take 24-bit dram byte addresses
R 0000 0000
W 8020 a001
W 8022 b002
W 8024 c003
W 8026 d004
W 8028 e005
W 802a f006
W 802c 1237
W 802e 4568
R 8024 c003
W 0002 0020
W 0004 0003
W 0006 0010
W 0000 0000
R 0000 0001
W 8020 dead
R 8022 0000
W 0000 0001
G
R 0000 0000
R 8020 a001
E 000300 b002a001
E 000302 d004c003
E 000304 f006e005
E 000306 45681237
E 000308 5a5a5184
P 000500 11223344
P 000502 55667788
P 000504 99aabbcc
W 808c 0bad
W 0002 0080
W 0004 0005
W 0006 000c
W 0000 0001
G
R 8080 3344
R 8082 1122
R 8084 7788
R 8086 5566
R 8088 bbcc
R 808a 99aa
R 808c 0bad
W 0004 0006
W 0000 0000
G
E 000600 11223344
E 000602 55667788
E 000604 99aabbcc
E 000606 5a5a5303
W 0002 0020
W 0004 0007
W 0000 0005
G
R 0000 0000
R 8020 a001
E 000700 5a5a5380

// File: tb.f
+incdir+common
common/dma_pkg.sv
dma/dma_regs.sv
dma/dma_engine.sv
rtl/local_ram.sv
rtl/dma_subsystem.sv
test/dram_model.sv
test/tb_dma.sv

// File: run.sh
#!/usr/bin/env bash
# build the DMA testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_dma \
  -f tb.f --Mdir obj_dir -o tb_dma_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dma_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
